//--- list.f
+incdir+verilog
verilog/mem_bus_pkg.sv
verilog/lane_steer.sv
verilog/bus_arbiter.sv
verilog/main_memory.sv
verilog/clint_timer.sv
verilog/mem_subsys_top.sv
testbench/tb_clock_gen.sv
testbench/mem_subsys_checker.sv
testbench/mem_subsys_assertions.sv
testbench/mem_subsys_tb.sv

//--- run.sh
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module mem_subsys_tb -f list.f -o simv \
  > build.log 2>&1 &&
  ./obj_dir/simv > sim.log 2>&1 ||
  { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "Done: errors found" sim.log &&
  { echo "simulation reported errors, see sim.log"; exit 1; } ||
  { grep -q "Done: no errors" sim.log ||
    { echo "simulation ended without a verdict"; exit 1; }; }
echo "simulation passed"
exit 0

//--- testbench/mem_subsys_tb.sv
`timescale 1ns/1ps
`include "mem_bus_macros.svh"

module mem_subsys_tb;
  import mem_bus_pkg::*;

  typedef struct packed {
    logic         m;       // 0 ifu, 1 lsu
    logic         we;
    logic [31:0]  adr;
    access_size_e size;
    logic [31:0]  wdat;
    logic         exp_err;
  } test_ent_t;

  logic      clk;
  logic      rst;
  core_req_t ifu_req;
  core_req_t lsu_req;
  core_rsp_t ifu_rsp;
  core_rsp_t lsu_rsp;
  logic      ifu_exp;
  logic      lsu_exp;
  int        err_count;
  test_ent_t tbl [64];
  int        n_ent;

  tb_clock_gen #(.PERIOD_NS(20), .RST_CYCLES(10)) tb_clock_gen_i (
    .clk_o (clk),
    .rst_o (rst)
  );

  mem_subsys_top mem_subsys_top_i (
    .clk       (clk),
    .rst       (rst),
    .ifu_req_i (ifu_req),
    .ifu_rsp_o (ifu_rsp),
    .lsu_req_i (lsu_req),
    .lsu_rsp_o (lsu_rsp)
  );

  mem_subsys_checker mem_subsys_checker_i (
    .clk_i         (clk),
    .rst_i         (rst),
    .ifu_req_i     (ifu_req),
    .ifu_rsp_i     (ifu_rsp),
    .ifu_exp_err_i (ifu_exp),
    .lsu_req_i     (lsu_req),
    .lsu_rsp_i     (lsu_rsp),
    .lsu_exp_err_i (lsu_exp),
    .err_count_o   (err_count)
  );

  task automatic add_entry(input logic m, input logic we, input logic [31:0] adr,
                           input access_size_e sz, input logic err);
    tbl[n_ent] = '{m: m, we: we, adr: adr, size: sz, wdat: $urandom(), exp_err: err};
    n_ent = n_ent + 1;
  endtask

  task automatic fill_table;
    n_ent = 0;
    add_entry(1'b0, 1'b1, `MEM_BASE + 32'h00, sz_word, 1'b0);
    add_entry(1'b0, 1'b1, `MEM_BASE + 32'h08, sz_half, 1'b0);
    add_entry(1'b0, 1'b1, `MEM_BASE + 32'h0A, sz_half, 1'b0);
    add_entry(1'b0, 1'b1, `MEM_BASE + 32'h0C, sz_byte, 1'b0);
    add_entry(1'b0, 1'b1, `MEM_BASE + 32'h0D, sz_byte, 1'b0);
    add_entry(1'b0, 1'b1, `MEM_BASE + 32'h0E, sz_half, 1'b0);
    add_entry(1'b0, 1'b0, `MEM_BASE + 32'h00, sz_byte, 1'b0); // every byte offset
    add_entry(1'b0, 1'b0, `MEM_BASE + 32'h01, sz_byte, 1'b0);
    add_entry(1'b0, 1'b0, `MEM_BASE + 32'h02, sz_byte, 1'b0);
    add_entry(1'b0, 1'b0, `MEM_BASE + 32'h03, sz_byte, 1'b0);
    add_entry(1'b0, 1'b0, `MEM_BASE + 32'h02, sz_half, 1'b0);
    add_entry(1'b0, 1'b0, `MEM_BASE + 32'h08, sz_word, 1'b0);
    add_entry(1'b0, 1'b0, `MEM_BASE + 32'h0C, sz_word, 1'b0);
    add_entry(1'b0, 1'b0, `MEM_BASE + 32'h0A, sz_half, 1'b0);
    add_entry(1'b0, 1'b0, `MEM_BASE + 32'h00, sz_word, 1'b0);
    add_entry(1'b1, 1'b0, `MTIME_HI_ADDR, sz_word, 1'b0);
    add_entry(1'b1, 1'b1, `MEM_BASE + 32'h104, sz_word, 1'b0); // high lane
    add_entry(1'b1, 1'b1, `MEM_BASE + 32'h100, sz_word, 1'b0);
    add_entry(1'b1, 1'b0, `MEM_BASE + 32'h105, sz_byte, 1'b0);
    add_entry(1'b1, 1'b0, `MEM_BASE + 32'h106, sz_byte, 1'b0);
    add_entry(1'b1, 1'b0, `MEM_BASE + 32'h107, sz_byte, 1'b0);
    add_entry(1'b1, 1'b0, `MEM_BASE + 32'h106, sz_half, 1'b0);
    add_entry(1'b1, 1'b1, `MEM_BASE + 32'h101, sz_word, 1'b1); // misaligned
    add_entry(1'b1, 1'b1, `MEM_BASE + 32'h103, sz_half, 1'b1);
    add_entry(1'b1, 1'b0, `MEM_BASE + 32'h102, sz_word, 1'b1);
    add_entry(1'b1, 1'b0, 32'h1000_0000, sz_word, 1'b1);      // unmapped
    add_entry(1'b1, 1'b1, `MEM_BASE + `MEM_BYTES, sz_word, 1'b1);
    add_entry(1'b1, 1'b0, `MEM_BASE + 32'h100, sz_word, 1'b0);
    add_entry(1'b1, 1'b0, `MEM_BASE + 32'h104, sz_word, 1'b0);
    add_entry(1'b1, 1'b0, `MTIME_LO_ADDR, sz_word, 1'b0);
    add_entry(1'b1, 1'b0, `MTIME_LO_ADDR, sz_word, 1'b0);
    add_entry(1'b1, 1'b1, `MTIME_LO_ADDR, sz_word, 1'b0);
    add_entry(1'b1, 1'b0, `MEM_BASE + 32'h00, sz_word, 1'b0); // final state of ifu data
    add_entry(1'b1, 1'b0, `MEM_BASE + 32'h08, sz_word, 1'b0);
    add_entry(1'b1, 1'b0, `MEM_BASE + 32'h0C, sz_word, 1'b0);
  endtask

  task automatic drive_req(input int m, input core_req_t r, input logic e);
    if (m == 1)
    begin
      lsu_req = r;
      lsu_exp = e;
    end
    else
    begin
      ifu_req = r;
      ifu_exp = e;
    end
  endtask

  function automatic logic got_response(input int m);
    return (m == 1) ? (lsu_rsp.ack | lsu_rsp.err) : (ifu_rsp.ack | ifu_rsp.err);
  endfunction

  task automatic run_master(input int m);
    core_req_t r;
    int        gap;
    for (int i = 0; i < n_ent; i++)
    begin
      if (int'(tbl[i].m) != m)
        continue;
      gap = int'($urandom_range(3));
      repeat (gap) @(posedge clk);
      @(posedge clk);
      #1;
      r      = '0;
      r.cyc  = 1'b1;
      r.stb  = 1'b1;
      r.we   = tbl[i].we;
      r.adr  = tbl[i].adr;
      r.size = tbl[i].size;
      r.wdat = tbl[i].wdat;
      drive_req(m, r, tbl[i].exp_err);
      do @(negedge clk); while (!got_response(m));
      @(posedge clk);
      #1;
      drive_req(m, '0, 1'b0); // drop stb after the response
    end
  endtask

  initial
  begin
    void'($urandom(32'h97dd_03bc));
    ifu_req = '0;
    lsu_req = '0;
    ifu_exp = 1'b0;
    lsu_exp = 1'b0;
    fill_table();
    @(posedge clk);
    while (rst)
      @(posedge clk);
    fork
      run_master(0);
      run_master(1);
    join
    repeat (4) @(posedge clk);
    $display("entries: %0d errors: %0d", n_ent, err_count);
    if (err_count == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // 20 cycles per entry plus reset
  initial
  begin
    #1;
    #((n_ent * 20 + 10) * 20);
    $display("timeout: the masters did not finish their requests in time");
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- testbench/mem_subsys_assertions.sv
`timescale 1ns/1ps

module mem_subsys_assertions
  import mem_bus_pkg::*;
(
  input logic      clk_i,
  input logic      rst_i,
  input core_req_t ifu_req_i,
  input core_req_t lsu_req_i,
  input core_rsp_t ifu_rsp_i,
  input core_rsp_t lsu_rsp_i,
  input core_req_t gnt_req_i,
  input logic      gnt_valid_i,
  input logic      gnt_lsu_i
);

  logic ifu_done;
  logic lsu_done;

  assign ifu_done = ifu_rsp_i.ack | ifu_rsp_i.err;
  assign lsu_done = lsu_rsp_i.ack | lsu_rsp_i.err;

  a_ifu_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    !(ifu_rsp_i.ack && ifu_rsp_i.err)) else $error("ifu ack and err high together");
  a_lsu_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    !(lsu_rsp_i.ack && lsu_rsp_i.err)) else $error("lsu ack and err high together");

  // answered only while asking and granted a cycle earlier
  a_ifu_owner: assert property (@(posedge clk_i) disable iff (rst_i)
    ifu_done |-> (ifu_req_i.stb && $past(gnt_valid_i && !gnt_lsu_i)))
    else $error("ifu response without grant");
  a_lsu_owner: assert property (@(posedge clk_i) disable iff (rst_i)
    lsu_done |-> (lsu_req_i.stb && $past(gnt_valid_i && gnt_lsu_i)))
    else $error("lsu response without grant");

  // granted request held until answered
  a_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (gnt_valid_i && !ifu_done && !lsu_done) |=> $stable(gnt_req_i))
    else $error("granted request changed before its response");

endmodule

bind bus_arbiter mem_subsys_assertions mem_subsys_assertions_i (
  .clk_i       (clk),
  .rst_i       (rst),
  .ifu_req_i   (ifu_req_i),
  .lsu_req_i   (lsu_req_i),
  .ifu_rsp_i   (ifu_rsp_o),
  .lsu_rsp_i   (lsu_rsp_o),
  .gnt_req_i   (gnt_req_o),
  .gnt_valid_i (gnt_valid_q),
  .gnt_lsu_i   (gnt_lsu_q)
);

//--- testbench/mem_subsys_checker.sv
`timescale 1ns/1ps
`include "mem_bus_macros.svh"

module mem_subsys_checker
  import mem_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  core_req_t ifu_req_i,
  input  core_rsp_t ifu_rsp_i,
  input  logic      ifu_exp_err_i,
  input  core_req_t lsu_req_i,
  input  core_rsp_t lsu_rsp_i,
  input  logic      lsu_exp_err_i,
  output int        err_count_o
);

  logic [7:0]  shadow [`MEM_BYTES];
  logic        known [`MEM_BYTES];
  core_req_t   req_a [2];
  core_rsp_t   rsp_a [2];
  logic        exp_err_a [2];
  logic        pending [2];
  logic        solo [2];   // started while the other master was quiet
  int          start_cyc [2];
  logic        lo_seen [2];
  logic [31:0] lo_val [2];
  int          lo_cyc [2];
  logic        next_valid;
  int          next_m;
  int          cyc;

  assign req_a[0]     = ifu_req_i;
  assign req_a[1]     = lsu_req_i;
  assign rsp_a[0]     = ifu_rsp_i;
  assign rsp_a[1]     = lsu_rsp_i;
  assign exp_err_a[0] = ifu_exp_err_i;
  assign exp_err_a[1] = lsu_exp_err_i;

  initial
  begin
    err_count_o = 0;
    for (int i = 0; i < `MEM_BYTES; i++)
      known[i] = 1'b0;
  end

  task automatic flag_error(input string msg);
    err_count_o = err_count_o + 1;
    $display("FAILED at %0t: %s", $time, msg);
  endtask

  task automatic check_response(input int m);
    core_req_t   r;
    core_rsp_t   s;
    int          n;
    int          off;
    logic [31:0] exp;
    logic [31:0] mask;
    r = req_a[m];
    s = rsp_a[m];
    if (!pending[m])
    begin
      flag_error($sformatf("master %0d got a response it did not ask for", m));
      return;
    end
    if (s.ack && s.err)
      flag_error($sformatf("master %0d saw ack and err together", m));
    if (s.err !== exp_err_a[m])
      flag_error($sformatf("master %0d adr %h err=%0b, expected %0b",
                           m, r.adr, s.err, exp_err_a[m]));
    if (solo[m] && (cyc - start_cyc[m]) != 2)
      flag_error($sformatf("master %0d adr %h latency %0d cycles, expected 2",
                           m, r.adr, cyc - start_cyc[m]));
    if (next_valid && next_m != m)
      flag_error($sformatf("master %0d served twice while the other waited", m));
    next_valid = pending[1-m];
    next_m     = 1 - m;
    pending[m] = 1'b0;
    if (!s.ack)
      return;
    n = (r.size == sz_byte) ? 1 : (r.size == sz_half) ? 2 : 4;
    if (r.adr >= `MEM_BASE && r.adr < (`MEM_BASE + `MEM_BYTES))
    begin
      off = int'(r.adr - `MEM_BASE);
      if (r.we)
      begin
        for (int i = 0; i < n; i++)
        begin
          shadow[off+i] = r.wdat[8*i +: 8];
          known[off+i]  = 1'b1;
        end
      end
      else
      begin
        exp  = '0;
        mask = '0;
        for (int i = 0; i < 4; i++)
        begin
          if (i >= n)
            mask[8*i +: 8] = 8'hff; // must be zero-extended
          else if (known[off+i])
          begin
            mask[8*i +: 8] = 8'hff;
            exp[8*i +: 8]  = shadow[off+i];
          end
        end
        if ((s.rdat & mask) !== exp)
          flag_error($sformatf("master %0d read %h got %h, expected %h (mask %h)",
                               m, r.adr, s.rdat, exp, mask));
      end
    end
    else if (!r.we && r.adr == `MTIME_HI_ADDR)
    begin
      if (s.rdat !== 32'd0)
        flag_error($sformatf("mtime high half %h, expected 0", s.rdat));
    end
    else if (!r.we && r.adr == `MTIME_LO_ADDR)
    begin
      if (lo_seen[m] && !(s.rdat > lo_val[m] &&
                          (s.rdat - lo_val[m]) >= 32'(cyc - lo_cyc[m])))
        flag_error($sformatf("mtime low went %h -> %h in %0d cycles",
                             lo_val[m], s.rdat, cyc - lo_cyc[m]));
      lo_seen[m] = 1'b1;
      lo_val[m]  = s.rdat;
      lo_cyc[m]  = cyc;
    end
  endtask

  // outputs are settled mid-cycle
  always @(negedge clk_i)
  begin
    if (rst_i)
    begin
      cyc        = 0;
      next_valid = 1'b0;
      next_m     = 0;
      for (int m = 0; m < 2; m++)
      begin
        pending[m] = 1'b0;
        lo_seen[m] = 1'b0;
      end
    end
    else
    begin
      cyc = cyc + 1;
      for (int m = 0; m < 2; m++)
      begin
        if (req_a[m].cyc && req_a[m].stb && !pending[m])
        begin
          pending[m]   = 1'b1;
          start_cyc[m] = cyc;
          solo[m]      = !(req_a[1-m].cyc && req_a[1-m].stb);
        end
      end
      for (int m = 0; m < 2; m++)
        if (rsp_a[m].ack || rsp_a[m].err)
          check_response(m);
    end
  end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 10
)
(
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial
  begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b0; // released just after an edge
  end

endmodule

//--- verilog/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top
  import mem_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  core_req_t ifu_req_i,
  output core_rsp_t ifu_rsp_o,
  input  core_req_t lsu_req_i,
  output core_rsp_t lsu_rsp_o
);

  core_req_t   gnt_req;
  wb_req_t     beat_req;
  wb_req_t     mem_req;
  wb_req_t     tmr_req;
  wb_rsp_t     mem_rsp;
  wb_rsp_t     tmr_rsp;
  wb_rsp_t     sel_rsp;
  logic        misaligned;
  logic [31:0] rdat;

  bus_arbiter bus_arbiter_i (
    .clk          (clk),
    .rst          (rst),
    .ifu_req_i    (ifu_req_i),
    .lsu_req_i    (lsu_req_i),
    .ifu_rsp_o    (ifu_rsp_o),
    .lsu_rsp_o    (lsu_rsp_o),
    .gnt_req_o    (gnt_req),
    .beat_req_i   (beat_req),
    .misaligned_i (misaligned),
    .rdat_i       (rdat),
    .mem_req_o    (mem_req),
    .mem_rsp_i    (mem_rsp),
    .tmr_req_o    (tmr_req),
    .tmr_rsp_i    (tmr_rsp),
    .sel_rsp_o    (sel_rsp)
  );

  lane_steer lane_steer_i (
    .req_i        (gnt_req),
    .rsp_i        (sel_rsp),
    .beat_o       (beat_req),
    .misaligned_o (misaligned),
    .rdat_o       (rdat)
  );

  main_memory main_memory_i (
    .clk   (clk),
    .rst   (rst),
    .req_i (mem_req),
    .rsp_o (mem_rsp)
  );

  clint_timer clint_timer_i (
    .clk   (clk),
    .rst   (rst),
    .req_i (tmr_req),
    .rsp_o (tmr_rsp)
  );

endmodule

//--- verilog/clint_timer.sv
`timescale 1ns/1ps
`include "mem_bus_macros.svh"

module clint_timer
  import mem_bus_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  logic [63:0] mtime_q;
  logic [31:0] half_q;
  logic        ack_q;
  logic        hit;

  assign hit = req_i.cyc & req_i.stb & !ack_q;

  always_ff @(posedge clk)
  begin
    if (rst)
      mtime_q <= 64'd0;
    else
      mtime_q <= mtime_q + 64'd1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      ack_q <= 1'b0;
    else
      ack_q <= hit; // writes acked, data dropped
  end

  // sample the half seen with the strobe
  always_ff @(posedge clk)
  begin
    if (hit && !req_i.we)
      half_q <= (req_i.adr == `MTIME_HI_ADDR) ? mtime_q[63:32] : mtime_q[31:0];
  end

  always_comb
  begin
    rsp_o              = '0;
    rsp_o.ack          = ack_q;
    rsp_o.dat.lanes.hi = half_q;
    rsp_o.dat.lanes.lo = half_q;
  end

endmodule

//--- verilog/main_memory.sv
`timescale 1ns/1ps
`include "mem_bus_macros.svh"

module main_memory
  import mem_bus_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  logic [63:0]           mem_q [`MEM_WORDS];
  logic [`MEM_IDX_W-1:0] idx;
  logic [63:0]           rdat_q;
  logic                  ack_q;
  logic                  hit;

  assign idx = req_i.adr[`MEM_IDX_W+2:3]; // doubleword index
  assign hit = req_i.cyc & req_i.stb & !ack_q;

  always_ff @(posedge clk)
  begin
    if (hit && req_i.we)
    begin
      for (int b = 0; b < `BEAT_BYTES; b++)
      begin
        if (req_i.sel[b])
          mem_q[idx][8*b +: 8] <= req_i.dat.dword[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (hit)
      rdat_q <= mem_q[idx];
  end

  // one ack per strobe
  always_ff @(posedge clk)
  begin
    if (rst)
      ack_q <= 1'b0;
    else
      ack_q <= hit;
  end

  always_comb
  begin
    rsp_o           = '0;
    rsp_o.ack       = ack_q;
    rsp_o.dat.dword = rdat_q;
  end

endmodule

//--- verilog/bus_arbiter.sv
`timescale 1ns/1ps
`include "mem_bus_macros.svh"

module bus_arbiter
  import mem_bus_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  core_req_t   ifu_req_i,
  input  core_req_t   lsu_req_i,
  output core_rsp_t   ifu_rsp_o,
  output core_rsp_t   lsu_rsp_o,
  output core_req_t   gnt_req_o,
  input  wb_req_t     beat_req_i,
  input  logic        misaligned_i,
  input  logic [31:0] rdat_i,
  output wb_req_t     mem_req_o,
  input  wb_rsp_t     mem_rsp_i,
  output wb_req_t     tmr_req_o,
  input  wb_rsp_t     tmr_rsp_i,
  output wb_rsp_t     sel_rsp_o
);

  logic gnt_valid_q;
  logic gnt_lsu_q;   // owner of the current grant
  logic last_lsu_q;  // who was served last
  logic err_q;
  logic ifu_want;
  logic lsu_want;
  logic pick_lsu;
  logic hit_mem;
  logic hit_tmr;
  logic mem_go;
  logic tmr_go;
  logic bad_acc;
  logic rsp_done;

  assign ifu_want = ifu_req_i.cyc & ifu_req_i.stb;
  assign lsu_want = lsu_req_i.cyc & lsu_req_i.stb;
  assign pick_lsu = lsu_want & (!ifu_want | !last_lsu_q);

  always_comb
  begin
    gnt_req_o     = gnt_lsu_q ? lsu_req_i : ifu_req_i;
    gnt_req_o.cyc = gnt_req_o.cyc & gnt_valid_q;
    gnt_req_o.stb = gnt_req_o.stb & gnt_valid_q;
  end

  // address decode on the granted request
  assign hit_mem = (gnt_req_o.adr >= `MEM_BASE) &&
                   (gnt_req_o.adr < (`MEM_BASE + `MEM_BYTES));
  assign hit_tmr = (gnt_req_o.adr == `MTIME_LO_ADDR) ||
                   (gnt_req_o.adr == `MTIME_HI_ADDR);
  assign mem_go  = hit_mem & !misaligned_i;
  assign tmr_go  = hit_tmr & !misaligned_i;
  assign bad_acc = !(mem_go | tmr_go);

  always_comb
  begin
    mem_req_o     = beat_req_i;
    mem_req_o.cyc = beat_req_i.cyc & mem_go;
    mem_req_o.stb = beat_req_i.stb & mem_go;
    tmr_req_o     = beat_req_i;
    tmr_req_o.cyc = beat_req_i.cyc & tmr_go;
    tmr_req_o.stb = beat_req_i.stb & tmr_go;
  end

  always_comb
  begin
    if (mem_go)
      sel_rsp_o = mem_rsp_i;
    else if (tmr_go)
      sel_rsp_o = tmr_rsp_i;
    else
    begin
      sel_rsp_o     = '0;
      sel_rsp_o.err = err_q; // answered here, no slave access
    end
  end

  assign rsp_done = gnt_valid_q & (sel_rsp_o.ack | sel_rsp_o.err);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      gnt_valid_q <= 1'b0;
      gnt_lsu_q   <= 1'b0;
      last_lsu_q  <= 1'b0;
    end
    else if (!gnt_valid_q)
    begin
      if (ifu_want | lsu_want)
      begin
        gnt_valid_q <= 1'b1;
        gnt_lsu_q   <= pick_lsu;
        last_lsu_q  <= pick_lsu;
      end
    end
    else if (rsp_done)
      gnt_valid_q <= 1'b0; // release after the response
  end

  // local err lines up with a slave ack
  always_ff @(posedge clk)
  begin
    if (rst)
      err_q <= 1'b0;
    else
      err_q <= gnt_valid_q & bad_acc & !err_q;
  end

  always_comb
  begin
    ifu_rsp_o = '0;
    lsu_rsp_o = '0;
    if (gnt_valid_q && !gnt_lsu_q)
    begin
      ifu_rsp_o.ack  = sel_rsp_o.ack;
      ifu_rsp_o.err  = sel_rsp_o.err;
      ifu_rsp_o.rdat = rdat_i;
    end
    if (gnt_valid_q && gnt_lsu_q)
    begin
      lsu_rsp_o.ack  = sel_rsp_o.ack;
      lsu_rsp_o.err  = sel_rsp_o.err;
      lsu_rsp_o.rdat = rdat_i;
    end
  end

endmodule

//--- verilog/lane_steer.sv
`timescale 1ns/1ps

module lane_steer
  import mem_bus_pkg::*;
(
  input  core_req_t   req_i,
  input  wb_rsp_t     rsp_i,
  output wb_req_t     beat_o,
  output logic        misaligned_o,
  output logic [31:0] rdat_o
);

  logic [4:0]  bit_off;
  logic [3:0]  mask4;
  logic [3:0]  sel4;
  logic [31:0] wshift;
  logic [31:0] lane;
  logic [31:0] rshift;

  assign bit_off = {req_i.adr[1:0], 3'b000};

  always_comb
  begin
    case (req_i.size)
      sz_byte: mask4 = 4'b0001;
      sz_half: mask4 = 4'b0011;
      default: mask4 = 4'b1111;
    endcase
    sel4   = mask4 << req_i.adr[1:0];
    wshift = req_i.wdat << bit_off;

    beat_o     = '0;
    beat_o.cyc = req_i.cyc;
    beat_o.stb = req_i.stb;
    beat_o.we  = req_i.we;
    beat_o.adr = req_i.adr;
    if (req_i.adr[2])
    begin
      beat_o.dat.lanes.hi = wshift;
      beat_o.sel          = {sel4, 4'b0000};
    end
    else
    begin
      beat_o.dat.lanes.lo = wshift;
      beat_o.sel          = {4'b0000, sel4};
    end
  end

  always_comb
  begin
    case (req_i.size)
      sz_byte: misaligned_o = 1'b0;
      sz_half: misaligned_o = req_i.adr[0];
      default: misaligned_o = |req_i.adr[1:0];
    endcase
  end

  // read side: pick lane, drop low bytes, zero-extend
  assign lane   = req_i.adr[2] ? rsp_i.dat.lanes.hi : rsp_i.dat.lanes.lo;
  assign rshift = lane >> bit_off;

  always_comb
  begin
    case (req_i.size)
      sz_byte: rdat_o = {24'b0, rshift[7:0]};
      sz_half: rdat_o = {16'b0, rshift[15:0]};
      default: rdat_o = rshift;
    endcase
  end

endmodule

//--- verilog/mem_bus_pkg.sv
package mem_bus_pkg;

  typedef enum logic [1:0] {
    sz_byte = 2'd0,
    sz_half = 2'd1,
    sz_word = 2'd2
  } access_size_e;

  // request as the core issues it
  typedef struct packed {
    logic         cyc;
    logic         stb;
    logic         we;
    logic [31:0]  adr;
    logic [31:0]  wdat;
    access_size_e size;
  } core_req_t;

  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] rdat;
  } core_rsp_t;

  typedef struct packed {
    logic [31:0] hi;
    logic [31:0] lo;
  } bus_lanes_t;

  // one 64-bit beat, whole or split into lanes
  typedef union packed {
    logic [63:0] dword;
    bus_lanes_t  lanes;
  } bus_beat_u;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    bus_beat_u   dat;
    logic [7:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic      ack;
    logic      err;
    bus_beat_u dat;
  } wb_rsp_t;

endpackage

//--- verilog/mem_bus_macros.svh
`ifndef MEM_BUS_MACROS_SVH
`define MEM_BUS_MACROS_SVH

// main memory window
`define MEM_BASE      32'h8000_0000
`define MEM_WORDS     512
`define MEM_IDX_W     9
`define MEM_BYTES     (`MEM_WORDS * 8)

// core-local timer, mtime as two 32-bit halves
`define MTIME_LO_ADDR 32'h0200_BFF8
`define MTIME_HI_ADDR 32'h0200_BFFC

// beat geometry
`define BEAT_BYTES    8
`define LANE_W        32

`endif
